// ==== verilog/fsc_geom_pkg.sv ====
package fsc_geom_pkg;

	// ------------------------------------------------------------------
	// image geometry
	// ------------------------------------------------------------------

	// horizontal sizes and coordinates
	localparam int IMG_WBITS = 12;
	// vertical sizes and coordinates
	localparam int IMG_HBITS = 12;

	// streams that can be configured
	localparam int NUM_STREAMS = 2;

	typedef logic [IMG_WBITS-1:0] img_w_t;
	typedef logic [IMG_HBITS-1:0] img_h_t;

	// source size, crop window, destination rectangle
	typedef struct packed {
		img_w_t width;
		img_h_t height;
		img_w_t win_left;
		img_h_t win_top;
		img_w_t win_width;
		img_h_t win_height;
		img_w_t dst_left;
		img_h_t dst_top;
		img_w_t dst_width;
		img_h_t dst_height;
	} stream_geom_t;

endpackage

// ==== verilog/fsc_reg_pkg.sv ====
package fsc_reg_pkg;

	localparam int REG_DW = 32;
	localparam int REG_AW = 8;

	// one host command, addr is a word index
	typedef struct packed {
		logic              write;
		logic [REG_AW-1:0] addr;
		logic [REG_DW-1:0] data;
	} cmd_t;

	// ------------------------------------------------------------------
	// register map
	// ------------------------------------------------------------------
	localparam int REG_CTRL = 0;

	// REG_CTRL bits
	localparam int CTRL_SOFT_RESETN = 0;
	localparam int CTRL_HOLD        = 1;
	localparam int CTRL_ORDER       = 2;
	localparam int CTRL_RUN_LSB     = 4;

	localparam int REG_STREAM_BASE = 1;
	localparam int REGS_PER_STREAM = 5;

	// offsets inside one stream block
	localparam int OFS_SIZE     = 0;
	localparam int OFS_WIN_ORG  = 1;
	localparam int OFS_WIN_SIZE = 2;
	localparam int OFS_DST_ORG  = 3;
	localparam int OFS_DST_SIZE = 4;

	// horizontal field high, vertical low
	localparam int FLD_H_LSB = 16;
	localparam int FLD_V_LSB = 0;

endpackage

// ==== verilog/cfg_stage_if.sv ====
`timescale 1ns/10ps

interface cfg_stage_if import fsc_geom_pkg::*; #(
	parameter int N_STREAMS = NUM_STREAMS
);

	// staged values, not yet live
	stream_geom_t         geom [N_STREAMS];
	logic [N_STREAMS-1:0] run;
	logic                 hold;
	logic                 order_1over2;

	modport src (
		output geom, run, hold, order_1over2
	);

	modport dst (
		input geom, run, hold, order_1over2
	);

endinterface

// ==== verilog/cmd_credit_fifo.sv ====
`timescale 1ns/10ps

module cmd_credit_fifo import fsc_reg_pkg::*; #(
	parameter int CMD_DEPTH = 4
) (
	input  logic i_clk,
	input  logic i_resetn,
	input  logic i_valid,
	input  cmd_t i_entry,
	output logic o_credit,
	output logic o_nempty,
	output cmd_t o_head,
	input  logic i_pop
);

	localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
	localparam int CNT_W = $clog2(CMD_DEPTH + 1);

	cmd_t             mem [CMD_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             pop;

	function automatic logic [PTR_W-1:0] ptr_next(logic [PTR_W-1:0] p);
		return (p == PTR_W'(CMD_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign pop      = i_pop && o_nempty;
	assign o_nempty = count != '0;
	assign o_head   = mem[rd_ptr];

	// occupancy is bounded by the sender's credits
	always_ff @(posedge i_clk) begin
		if (i_valid)
			mem[wr_ptr] <= i_entry;
	end

	always_ff @(posedge i_clk) begin
		if (!i_resetn) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			o_credit <= 1'b0;
		end else begin
			if (i_valid)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop)
				rd_ptr <= ptr_next(rd_ptr);
			if (i_valid && !pop)
				count <= count + 1'b1;
			else if (pop && !i_valid)
				count <= count - 1'b1;
			// one credit back per drained entry
			o_credit <= pop;
		end
	end

endmodule

// ==== verilog/cfg_regfile.sv ====
`timescale 1ns/10ps

module cfg_regfile import fsc_reg_pkg::*, fsc_geom_pkg::*; #(
	parameter int N_STREAMS = NUM_STREAMS
) (
	input  logic              i_clk,
	input  logic              i_resetn,
	input  logic              i_nempty,
	input  cmd_t              i_head,
	output logic              o_pop,
	input  logic              i_rsp_credit,
	output logic              o_rsp_valid,
	output logic [REG_DW-1:0] o_rsp_data,
	output logic              o_soft_resetn,
	cfg_stage_if.src          stage
);

	localparam int CRED_W = 8;

	logic                 r_soft_resetn;
	logic                 r_hold;
	logic                 r_order;
	logic [N_STREAMS-1:0] r_run;
	stream_geom_t         r_geom [N_STREAMS];
	logic [CRED_W-1:0]    rsp_cnt;
	logic                 rd_pop;
	logic                 wr_en;
	logic [REG_DW-1:0]    rd_word;
	img_w_t               wr_h;
	img_h_t               wr_v;

	function automatic logic [REG_DW-1:0] pair_word(img_w_t h, img_h_t v);
		logic [REG_DW-1:0] w;
		w = '0;
		w[FLD_H_LSB +: IMG_WBITS] = h;
		w[FLD_V_LSB +: IMG_HBITS] = v;
		return w;
	endfunction

	// a read at the head waits for a response credit and blocks the rest
	assign o_pop  = i_nempty && (i_head.write || rsp_cnt != '0);
	assign rd_pop = o_pop && !i_head.write;
	assign wr_en  = o_pop && i_head.write;
	assign wr_h   = i_head.data[FLD_H_LSB +: IMG_WBITS];
	assign wr_v   = i_head.data[FLD_V_LSB +: IMG_HBITS];

	always_ff @(posedge i_clk) begin
		if (!i_resetn)
			rsp_cnt <= '0;
		else if (i_rsp_credit && !rd_pop)
			rsp_cnt <= rsp_cnt + 1'b1;
		else if (rd_pop && !i_rsp_credit)
			rsp_cnt <= rsp_cnt - 1'b1;
	end

	// ------------------------------------------------------------------
	// staged registers
	// ------------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (!i_resetn) begin
			r_soft_resetn <= 1'b0;
			r_hold        <= 1'b0;
			r_order       <= 1'b0;
			r_run         <= N_STREAMS'(1);
			o_soft_resetn <= 1'b0;
		end else begin
			if (wr_en && i_head.addr == REG_AW'(REG_CTRL)) begin
				r_soft_resetn <= i_head.data[CTRL_SOFT_RESETN];
				r_hold        <= i_head.data[CTRL_HOLD];
				r_order       <= i_head.data[CTRL_ORDER];
				r_run         <= i_head.data[CTRL_RUN_LSB +: N_STREAMS];
			end
			// leaves the block one cycle behind the register
			o_soft_resetn <= r_soft_resetn;
		end
	end

	for (genvar k = 0; k < N_STREAMS; k++) begin : g_stream
		localparam int BASE = REG_STREAM_BASE + k * REGS_PER_STREAM;
		always_ff @(posedge i_clk) begin
			if (!i_resetn)
				r_geom[k] <= '0;
			else if (wr_en) begin
				case (i_head.addr)
				REG_AW'(BASE + OFS_SIZE): {r_geom[k].width, r_geom[k].height} <= {wr_h, wr_v};
				REG_AW'(BASE + OFS_WIN_ORG): {r_geom[k].win_left, r_geom[k].win_top} <= {wr_h, wr_v};
				REG_AW'(BASE + OFS_WIN_SIZE): {r_geom[k].win_width, r_geom[k].win_height} <= {wr_h, wr_v};
				REG_AW'(BASE + OFS_DST_ORG): {r_geom[k].dst_left, r_geom[k].dst_top} <= {wr_h, wr_v};
				REG_AW'(BASE + OFS_DST_SIZE): {r_geom[k].dst_width, r_geom[k].dst_height} <= {wr_h, wr_v};
				default: ;
				endcase
			end
		end
	end

	// read word, zero outside the map
	always_comb begin
		rd_word = '0;
		if (i_head.addr == REG_AW'(REG_CTRL)) begin
			rd_word[CTRL_SOFT_RESETN]          = r_soft_resetn;
			rd_word[CTRL_HOLD]                 = r_hold;
			rd_word[CTRL_ORDER]                = r_order;
			rd_word[CTRL_RUN_LSB +: N_STREAMS] = r_run;
		end
		for (int k = 0; k < N_STREAMS; k++) begin
			case (int'(i_head.addr) - (REG_STREAM_BASE + k * REGS_PER_STREAM))
			OFS_SIZE: rd_word = pair_word(r_geom[k].width, r_geom[k].height);
			OFS_WIN_ORG: rd_word = pair_word(r_geom[k].win_left, r_geom[k].win_top);
			OFS_WIN_SIZE: rd_word = pair_word(r_geom[k].win_width, r_geom[k].win_height);
			OFS_DST_ORG: rd_word = pair_word(r_geom[k].dst_left, r_geom[k].dst_top);
			OFS_DST_SIZE: rd_word = pair_word(r_geom[k].dst_width, r_geom[k].dst_height);
			default: ;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_resetn)
			o_rsp_valid <= 1'b0;
		else
			o_rsp_valid <= rd_pop;
	end

	always_ff @(posedge i_clk) begin
		if (rd_pop)
			o_rsp_data <= rd_word;
	end

	assign stage.geom         = r_geom;
	assign stage.run          = r_run;
	assign stage.hold         = r_hold;
	assign stage.order_1over2 = r_order;

endmodule

// ==== verilog/frame_apply.sv ====
`timescale 1ns/10ps

module frame_apply import fsc_geom_pkg::*; #(
	parameter int N_STREAMS = NUM_STREAMS
) (
	input  logic         i_clk,
	input  logic         i_resetn,
	input  logic         i_fsync,
	cfg_stage_if.dst     stage,
	output logic         o_fsync,
	output logic         o_order_1over2,
	output stream_geom_t o_geom [N_STREAMS]
);

	logic fsync_s1;
	logic fsync_s2;
	logic fsync_s3;
	logic fsync_edge;
	logic apply;

	// ------------------------------------------------------------------
	// fsync synchronizer and edge detect
	// ------------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (!i_resetn) begin
			fsync_s1 <= 1'b0;
			fsync_s2 <= 1'b0;
			fsync_s3 <= 1'b0;
		end else begin
			fsync_s1 <= i_fsync;
			fsync_s2 <= fsync_s1;
			fsync_s3 <= fsync_s2;
		end
	end

	assign fsync_edge = fsync_s2 && !fsync_s3;

	// hold keeps the live set while the host is mid-update
	assign apply = fsync_edge && !stage.hold;

	// pulse lines up with the new live values
	always_ff @(posedge i_clk) begin
		if (!i_resetn)
			o_fsync <= 1'b0;
		else
			o_fsync <= fsync_edge;
	end

	always_ff @(posedge i_clk) begin
		if (!i_resetn)
			o_order_1over2 <= 1'b0;
		else if (apply)
			o_order_1over2 <= stage.order_1over2;
	end

	// ------------------------------------------------------------------
	// live geometry per stream
	// ------------------------------------------------------------------
	for (genvar k = 0; k < N_STREAMS; k++) begin : g_live
		always_ff @(posedge i_clk) begin
			if (!i_resetn)
				o_geom[k] <= '0;
			else if (apply)
				// stopped stream goes to zero size
				o_geom[k] <= stage.run[k] ? stage.geom[k] : '0;
		end
	end

endmodule

// ==== verilog/fsync_ctl_top.sv ====
`timescale 1ns/10ps

module fsync_ctl_top import fsc_reg_pkg::*, fsc_geom_pkg::*; #(
	parameter int CMD_DEPTH = 4,
	parameter int N_STREAMS = NUM_STREAMS
) (
	input  logic              o_clk,
	input  logic              o_resetn,
	// command channel
	input  logic              i_cmd_valid,
	input  logic              i_cmd_write,
	input  logic [REG_AW-1:0] i_cmd_addr,
	input  logic [REG_DW-1:0] i_cmd_data,
	output logic              o_cmd_credit,
	// response channel
	input  logic              i_rsp_credit,
	output logic              o_rsp_valid,
	output logic [REG_DW-1:0] o_rsp_data,
	// frame side
	input  logic              i_fsync,
	output logic              o_fsync,
	output logic              o_soft_resetn,
	output logic              o_order_1over2,
	output stream_geom_t      o_geom [N_STREAMS]
);

	cmd_t cmd_in;
	cmd_t cmd_head;
	logic cmd_nempty;
	logic cmd_pop;

	assign cmd_in = '{write: i_cmd_write, addr: i_cmd_addr, data: i_cmd_data};

	cfg_stage_if #(.N_STREAMS(N_STREAMS)) stage_if ();

	cmd_credit_fifo #(.CMD_DEPTH(CMD_DEPTH)) i_cmd_fifo (
		.i_clk    (o_clk),
		.i_resetn (o_resetn),
		.i_valid  (i_cmd_valid),
		.i_entry  (cmd_in),
		.o_credit (o_cmd_credit),
		.o_nempty (cmd_nempty),
		.o_head   (cmd_head),
		.i_pop    (cmd_pop)
	);

	cfg_regfile #(.N_STREAMS(N_STREAMS)) i_regfile (
		.i_clk         (o_clk),
		.i_resetn      (o_resetn),
		.i_nempty      (cmd_nempty),
		.i_head        (cmd_head),
		.o_pop         (cmd_pop),
		.i_rsp_credit  (i_rsp_credit),
		.o_rsp_valid   (o_rsp_valid),
		.o_rsp_data    (o_rsp_data),
		.o_soft_resetn (o_soft_resetn),
		.stage         (stage_if.src)
	);

	frame_apply #(.N_STREAMS(N_STREAMS)) i_frame_apply (
		.i_clk          (o_clk),
		.i_resetn       (o_resetn),
		.i_fsync        (i_fsync),
		.stage          (stage_if.dst),
		.o_fsync        (o_fsync),
		.o_order_1over2 (o_order_1over2),
		.o_geom         (o_geom)
	);

endmodule

// ==== testbench/fsync_ctl_chk.sv ====
`timescale 1ns/10ps

module fsync_ctl_chk import fsc_geom_pkg::*; #(
	parameter int CMD_DEPTH = 4,
	parameter int N_STREAMS = NUM_STREAMS
) (
	input logic         o_clk,
	input logic         o_resetn,
	input logic         i_cmd_valid,
	input logic         o_cmd_credit,
	input logic         i_rsp_credit,
	input logic         o_rsp_valid,
	input logic         o_fsync,
	input logic         o_order_1over2,
	input stream_geom_t o_geom [N_STREAMS]
);

	localparam int GW = $bits(stream_geom_t);

	int                      cmd_cred;
	int                      rsp_cred;
	int                      fail_cnt = 0;
	logic [N_STREAMS*GW-1:0] live_flat;

	always_comb begin
		for (int k = 0; k < N_STREAMS; k++)
			live_flat[k*GW +: GW] = o_geom[k];
	end

	// credits as seen from both ends of the channels
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			cmd_cred <= CMD_DEPTH;
			rsp_cred <= 0;
		end else begin
			cmd_cred <= cmd_cred + int'(o_cmd_credit) - int'(i_cmd_valid);
			rsp_cred <= rsp_cred + int'(i_rsp_credit) - int'(o_rsp_valid);
		end
	end

	// ------------------------------------------------------------------
	// protocol and timing
	// ------------------------------------------------------------------
	a_cmd_credit: assert property (@(posedge o_clk) disable iff (!o_resetn)
		i_cmd_valid |-> cmd_cred > 0)
		else begin
			fail_cnt++;
			$error("command sent without a credit");
		end

	a_rsp_credit: assert property (@(posedge o_clk) disable iff (!o_resetn)
		o_rsp_valid |-> rsp_cred > 0)
		else begin
			fail_cnt++;
			$error("response sent without a response credit");
		end

	a_fsync_width: assert property (@(posedge o_clk) disable iff (!o_resetn)
		o_fsync |=> !o_fsync)
		else begin
			fail_cnt++;
			$error("o_fsync longer than one cycle");
		end

	a_live_change: assert property (@(posedge o_clk) disable iff (!o_resetn)
		!$stable({live_flat, o_order_1over2}) |-> $rose(o_fsync))
		else begin
			fail_cnt++;
			$error("live outputs changed outside a frame start");
		end

endmodule

bind fsync_ctl_top fsync_ctl_chk #(.CMD_DEPTH(CMD_DEPTH), .N_STREAMS(N_STREAMS)) i_chk (
	.o_clk          (o_clk),
	.o_resetn       (o_resetn),
	.i_cmd_valid    (i_cmd_valid),
	.o_cmd_credit   (o_cmd_credit),
	.i_rsp_credit   (i_rsp_credit),
	.o_rsp_valid    (o_rsp_valid),
	.o_fsync        (o_fsync),
	.o_order_1over2 (o_order_1over2),
	.o_geom         (o_geom)
);

// ==== testbench/tb_fsync_ctl.sv ====
`timescale 1ns/10ps

module tb_fsync_ctl import fsc_reg_pkg::*, fsc_geom_pkg::*; #(
	parameter int CMD_DEPTH = 4,
	parameter int N_STREAMS = NUM_STREAMS
);

	localparam int TIMEOUT  = 4000;
	localparam int NUM_REGS = REG_STREAM_BASE + N_STREAMS * REGS_PER_STREAM;

	logic              o_clk = 1'b0;
	logic              o_resetn;
	logic              i_cmd_valid;
	logic              i_cmd_write;
	logic [REG_AW-1:0] i_cmd_addr;
	logic [REG_DW-1:0] i_cmd_data;
	logic              o_cmd_credit;
	logic              i_rsp_credit;
	logic              o_rsp_valid;
	logic [REG_DW-1:0] o_rsp_data;
	logic              i_fsync;
	logic              o_fsync;
	logic              o_soft_resetn;
	logic              o_order_1over2;
	stream_geom_t      o_geom [N_STREAMS];

	logic [31:0]       seed = 32'h6d84;
	logic [REG_DW-1:0] shadow [NUM_REGS];
	logic [REG_DW-1:0] exp_q [$];
	logic [REG_DW-1:0] rsp_exp;
	stream_geom_t      live_exp [N_STREAMS];
	logic              order_exp;
	int                credits;
	int                cycles;
	int                rsp_seen;
	int                rsp_mark;

	fsync_ctl_top #(.CMD_DEPTH(CMD_DEPTH), .N_STREAMS(N_STREAMS)) i_fsync_ctl_top (.*);

	always #10 o_clk = ~o_clk;

	function automatic logic [31:0] next_random();
		seed = seed ^ (seed << 13);
		seed = seed ^ (seed >> 17);
		seed = seed ^ (seed << 5);
		return seed;
	endfunction

	// bits that a register keeps
	function automatic logic [REG_DW-1:0] field_mask(int idx);
		if (idx == REG_CTRL)
			return 32'h7 | (((32'd1 << N_STREAMS) - 32'd1) << CTRL_RUN_LSB);
		return (idx < NUM_REGS) ? 32'h0fff_0fff : '0;
	endfunction

	// five h/v pairs in struct order
	function automatic stream_geom_t staged_geom(int k);
		int           b;
		stream_geom_t g;
		b = REG_STREAM_BASE + k * REGS_PER_STREAM;
		for (int i = 0; i < REGS_PER_STREAM; i++)
			g[$bits(stream_geom_t) - 24*i - 1 -: 24] = {shadow[b+i][27:16], shadow[b+i][11:0]};
		return g;
	endfunction

	task automatic stop_run(string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_value(string name, logic [127:0] exp, logic [127:0] act);
		assert (exp === act)
		else stop_run($sformatf("[FAIL] %0t %s expected %0h got %0h", $time, name, exp, act));
	endtask

	task automatic check_live();
		for (int k = 0; k < N_STREAMS; k++)
			check_value($sformatf("o_geom[%0d]", k), live_exp[k], o_geom[k]);
		check_value("o_order_1over2", order_exp, o_order_1over2);
	endtask

	task automatic send_cmd(logic write, int addr, logic [REG_DW-1:0] data);
		repeat (next_random() % 3) @(posedge o_clk);
		while (credits == 0)
			@(posedge o_clk);
		@(posedge o_clk);
		i_cmd_valid <= 1'b1;
		i_cmd_write <= write;
		i_cmd_addr  <= REG_AW'(addr);
		i_cmd_data  <= data;
		credits--;
		if (write && addr < NUM_REGS)
			shadow[addr] = data & field_mask(addr);
		else if (!write)
			exp_q.push_back((addr < NUM_REGS) ? shadow[addr] : '0);
		@(posedge o_clk);
		i_cmd_valid <= 1'b0;
	endtask

	task automatic give_rsp_credits(int n);
		repeat (n) begin
			repeat (next_random() % 4) @(posedge o_clk);
			@(posedge o_clk);
			i_rsp_credit <= 1'b1;
			@(posedge o_clk);
			i_rsp_credit <= 1'b0;
		end
	endtask

	// all credits back and every read answered
	task automatic wait_idle();
		while (credits != CMD_DEPTH || exp_q.size() != 0)
			@(posedge o_clk);
		// soft reset output trails the register by a cycle
		@(negedge o_clk);
		check_value("o_soft_resetn", shadow[REG_CTRL][CTRL_SOFT_RESETN], o_soft_resetn);
	endtask

	task automatic pulse_fsync();
		@(posedge o_clk);
		i_fsync <= 1'b1;
		for (int n = 0; n < 4; n++) begin
			@(negedge o_clk);
			check_value("o_fsync", n == 3, o_fsync);
		end
		if (!shadow[REG_CTRL][CTRL_HOLD]) begin
			order_exp = shadow[REG_CTRL][CTRL_ORDER];
			for (int k = 0; k < N_STREAMS; k++)
				live_exp[k] = shadow[REG_CTRL][CTRL_RUN_LSB + k] ? staged_geom(k) : '0;
		end
		check_live();
		@(posedge o_clk);
		i_fsync <= 1'b0;
		repeat (4) @(posedge o_clk);
	endtask

	always @(negedge o_clk) begin
		cycles++;
		if (cycles > TIMEOUT)
			stop_run($sformatf("run did not finish within %0d cycles", TIMEOUT));
		if (i_fsync_ctl_top.i_chk.fail_cnt != 0)
			stop_run("a bound protocol or timing assertion failed");
		if (o_cmd_credit)
			credits++;
		assert (credits <= CMD_DEPTH)
		else stop_run("more command credits came back than commands were sent");
		if (o_rsp_valid) begin
			rsp_seen++;
			assert (exp_q.size() != 0)
			else stop_run("response arrived with no read outstanding");
			rsp_exp = exp_q.pop_front();
			check_value("o_rsp_data", rsp_exp, o_rsp_data);
		end
	end

	initial begin
		o_resetn     = 1'b0;
		i_cmd_valid  = 1'b0;
		i_cmd_write  = 1'b0;
		i_cmd_addr   = '0;
		i_cmd_data   = '0;
		i_rsp_credit = 1'b0;
		i_fsync      = 1'b0;
		credits      = CMD_DEPTH;
		cycles       = 0;
		rsp_seen     = 0;
		order_exp    = 1'b0;
		foreach (shadow[i])
			shadow[i] = '0;
		shadow[REG_CTRL][CTRL_RUN_LSB] = 1'b1;
		foreach (live_exp[k])
			live_exp[k] = '0;
		repeat (5) @(posedge o_clk);
		o_resetn <= 1'b1;

		@(negedge o_clk);
		check_value("o_cmd_credit", 0, o_cmd_credit);
		check_value("o_rsp_valid", 0, o_rsp_valid);
		check_value("o_fsync", 0, o_fsync);
		check_value("o_soft_resetn", 0, o_soft_resetn);
		check_live();

		// ------------------------------------------------------------------
		// writes over the map and past it and a full read back
		// ------------------------------------------------------------------
		send_cmd(1'b1, REG_CTRL, 32'hffff_fffd);
		for (int a = REG_STREAM_BASE; a < NUM_REGS + 2; a++)
			send_cmd(1'b1, a, next_random());
		wait_idle();
		fork
			for (int a = 0; a < NUM_REGS + 2; a++)
				send_cmd(1'b0, a, '0);
			give_rsp_credits(NUM_REGS + 2);
		join
		wait_idle();

		// read at the head with no response credit blocks the FIFO
		send_cmd(1'b0, REG_CTRL, '0);
		send_cmd(1'b1, REG_CTRL, 32'h34);
		for (int i = 2; i < CMD_DEPTH; i++)
			send_cmd(1'b0, i - 1, '0);
		rsp_mark = rsp_seen;
		repeat (20) @(posedge o_clk);
		assert (credits == 0 && rsp_seen == rsp_mark)
		else stop_run("commands or responses moved while reads had no response credit");
		give_rsp_credits(CMD_DEPTH - 1);
		wait_idle();

		// ------------------------------------------------------------------
		// frame apply, stream 1 stopped
		// ------------------------------------------------------------------
		send_cmd(1'b1, REG_CTRL, 32'h15);
		wait_idle();
		pulse_fsync();

		// hold set while stream 1 is rewritten
		send_cmd(1'b1, REG_CTRL, 32'h32);
		for (int a = REG_STREAM_BASE + REGS_PER_STREAM; a < NUM_REGS; a++)
			send_cmd(1'b1, a, next_random());
		wait_idle();
		pulse_fsync();
		send_cmd(1'b1, REG_CTRL, 32'h30);
		wait_idle();
		pulse_fsync();

		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== src.f ====
verilog/fsc_geom_pkg.sv
verilog/fsc_reg_pkg.sv
verilog/cfg_stage_if.sv
verilog/cmd_credit_fifo.sv
verilog/cfg_regfile.sv
verilog/frame_apply.sv
verilog/fsync_ctl_top.sv
testbench/fsync_ctl_chk.sv
testbench/tb_fsync_ctl.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fsync_ctl
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Testbench failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
